/* design/dmem_pkg.sv */
// ################################################
// Data-memory bus widths, byte selects and the
// store sequencer states.
// ################################################

`default_nettype none

package dmem_pkg;

  localparam int DADDR_W = 32;
  localparam int DDATA_W = 16;
  localparam int SEL_W   = 2;

  localparam logic [SEL_W-1:0] SEL_BYTE = 2'b01;
  localparam logic [SEL_W-1:0] SEL_HALF = 2'b11;

  // Address step between the two halves of a long store
  localparam int HALF_STEP = 2;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FIRST,
    ST_SECOND
  } store_state_e;

endpackage

`default_nettype wire

/* design/exec_alu.sv */
// ################################################
// ALU stage. Registers results, keeps the cmp flags
// and resolves branches against them. A taken
// branch squashes the following issue.
// ################################################

`default_nettype none

module exec_alu
(
  input  logic                             clk_i,
  input  logic                             rst_i,
  exec_if.sink                             iss,
  output logic                             reg_we_o,
  output logic [exec_pkg::XLEN-1:0]        result_o,
  output logic [exec_pkg::REG_IDX_W-1:0]   dst_idx_o,
  output logic                             branch_o,
  output logic [exec_pkg::XLEN-1:0]        branch_target_o
);

  localparam int XLEN = exec_pkg::XLEN;

  logic [XLEN-1:0] diff_ab;
  logic [XLEN-1:0] diff_ba;
  logic [XLEN-1:0] incdec;
  logic [XLEN-1:0] rel_target;
  logic [XLEN-1:0] alu_res;
  logic            alu_we;
  logic            cond;
  logic            take;
  exec_pkg::cc_t   flags;
  exec_pkg::cc_t   cc_next;

  assign diff_ab = iss.reg_a - iss.reg_b;
  assign diff_ba = iss.reg_b - iss.reg_a;

  // Mixed signs decide signed order directly
  assign cc_next.eq  = (iss.reg_a == iss.reg_b);
  assign cc_next.lt  = (iss.reg_a[XLEN-1] ^ iss.reg_b[XLEN-1]) ? iss.reg_a[XLEN-1]
                                                               : diff_ab[XLEN-1];
  assign cc_next.gt  = (iss.reg_a[XLEN-1] ^ iss.reg_b[XLEN-1]) ? iss.reg_b[XLEN-1]
                                                               : diff_ba[XLEN-1];
  assign cc_next.ltu = (iss.reg_a < iss.reg_b);
  assign cc_next.gtu = (iss.reg_a > iss.reg_b);

  // inc/dec only use the low byte of the offset field
  assign incdec = {{(XLEN-exec_pkg::INCDEC_W){1'b0}}, iss.offset[exec_pkg::INCDEC_W-1:0]};

  assign rel_target = iss.pc + XLEN'(exec_pkg::PC_INC)
                    + {{(XLEN-exec_pkg::OFFSET_W-1){iss.offset[exec_pkg::OFFSET_W-1]}},
                       iss.offset, 1'b0};

  always_comb
  begin
    alu_res = '0;
    alu_we  = 1'b1;
    case (iss.op)
      exec_pkg::OP_ADD:   alu_res = iss.reg_a + iss.reg_b;
      exec_pkg::OP_SUB:   alu_res = diff_ab;
      exec_pkg::OP_AND:   alu_res = iss.reg_a & iss.reg_b;
      exec_pkg::OP_OR:    alu_res = iss.reg_a | iss.reg_b;
      exec_pkg::OP_XOR:   alu_res = iss.reg_a ^ iss.reg_b;
      exec_pkg::OP_ASHL:  alu_res = iss.reg_a << iss.reg_b;
      exec_pkg::OP_ASHR:  alu_res = $signed(iss.reg_a) >>> iss.reg_b;
      exec_pkg::OP_LSHR:  alu_res = iss.reg_a >> iss.reg_b;
      exec_pkg::OP_INC:   alu_res = iss.reg_a + incdec;
      exec_pkg::OP_DEC:   alu_res = iss.reg_a - incdec;
      exec_pkg::OP_MOV:   alu_res = iss.reg_b;
      exec_pkg::OP_NEG:   alu_res = -iss.reg_b;
      exec_pkg::OP_NOT:   alu_res = ~iss.reg_b;
      exec_pkg::OP_SEX_B: alu_res = {{(XLEN-8){iss.reg_b[7]}}, iss.reg_b[7:0]};
      exec_pkg::OP_SEX_S: alu_res = {{(XLEN-16){iss.reg_b[15]}}, iss.reg_b[15:0]};
      exec_pkg::OP_ZEX_B: alu_res = {{(XLEN-8){1'b0}}, iss.reg_b[7:0]};
      exec_pkg::OP_ZEX_S: alu_res = {{(XLEN-16){1'b0}}, iss.reg_b[15:0]};
      exec_pkg::OP_LDI:   alu_res = iss.operand;
      default:            alu_we  = 1'b0;
    endcase
  end

  // Conditions read the stored flags, not this cycle's operands
  always_comb
  begin
    case (iss.op)
      exec_pkg::OP_BEQ:  cond = flags.eq;
      exec_pkg::OP_BNE:  cond = ~flags.eq;
      exec_pkg::OP_BLT:  cond = flags.lt;
      exec_pkg::OP_BLTU: cond = flags.ltu;
      exec_pkg::OP_BGT:  cond = flags.gt;
      exec_pkg::OP_BGTU: cond = flags.gtu;
      exec_pkg::OP_BLE:  cond = flags.eq | flags.lt;
      exec_pkg::OP_BLEU: cond = flags.eq | flags.ltu;
      exec_pkg::OP_BGE:  cond = flags.eq | flags.gt;
      exec_pkg::OP_BGEU: cond = flags.eq | flags.gtu;
      default:           cond = 1'b0;
    endcase
  end

  assign take       = cond | (iss.op == exec_pkg::OP_JMPA);
  assign iss.squash = iss.valid & take;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      reg_we_o <= 1'b0;
      branch_o <= 1'b0;
      flags    <= '0;
    end
    else
    begin
      reg_we_o <= iss.valid & alu_we;
      branch_o <= iss.valid & take;
      if (iss.valid && iss.op == exec_pkg::OP_CMP)
      begin
        flags <= cc_next;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (iss.valid && alu_we)
    begin
      result_o  <= alu_res;
      dst_idx_o <= iss.dst_idx;
    end
    if (iss.valid && take)
    begin
      branch_target_o <= (iss.op == exec_pkg::OP_JMPA) ? iss.operand : rel_target;
    end
  end

endmodule

`default_nettype wire

/* design/exec_if.sv */
// ################################################
// One issued instruction, from the issue register
// to the ALU and store stages, plus squash back.
// ################################################

`default_nettype none

interface exec_if;

  // High for one cycle per new instruction
  logic                                valid;
  exec_pkg::opcode_e                   op;
  logic [exec_pkg::XLEN-1:0]           reg_a;
  logic [exec_pkg::XLEN-1:0]           reg_b;
  logic [exec_pkg::XLEN-1:0]           operand;
  logic [exec_pkg::OFFSET_W-1:0]       offset;
  logic [exec_pkg::XLEN-1:0]           pc;
  logic [exec_pkg::REG_IDX_W-1:0]      dst_idx;
  // Taken branch in the ALU kills the next issue
  logic                                squash;

  modport issue (output valid, op, reg_a, reg_b, operand, offset, pc, dst_idx,
                 input  squash);

  modport sink  (input  valid, op, reg_a, reg_b, operand, offset, pc, dst_idx,
                 output squash);

endinterface

`default_nettype wire

/* design/exec_issue.sv */
// ################################################
// Issue register. Takes one instruction per cycle
// while ready_o is high and presents it as a
// one-cycle strobe on the instruction bus.
// ################################################

`default_nettype none

module exec_issue
(
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic                             valid_i,
  input  exec_pkg::opcode_e                op_i,
  input  logic [exec_pkg::XLEN-1:0]        reg_a_i,
  input  logic [exec_pkg::XLEN-1:0]        reg_b_i,
  input  logic [exec_pkg::XLEN-1:0]        operand_i,
  input  logic [exec_pkg::OFFSET_W-1:0]    offset_i,
  input  logic [exec_pkg::XLEN-1:0]        pc_i,
  input  logic [exec_pkg::REG_IDX_W-1:0]   dst_idx_i,
  input  logic                             busy_i,
  output logic                             ready_o,
  exec_if.issue                            iss
);

  logic accept;

  // Memory back-pressure stops new issues
  assign ready_o = ~busy_i;
  assign accept  = valid_i & ready_o;

  // A squashed slot still loads but never strobes
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      iss.valid <= 1'b0;
    end
    else
    begin
      iss.valid <= accept & ~iss.squash;
    end
  end

  // Held unchanged while the source waits on ready_o
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      iss.op      <= op_i;
      iss.reg_a   <= reg_a_i;
      iss.reg_b   <= reg_b_i;
      iss.operand <= operand_i;
      iss.offset  <= offset_i;
      iss.pc      <= pc_i;
      iss.dst_idx <= dst_idx_i;
    end
  end

endmodule

`default_nettype wire

/* design/exec_pkg.sv */
// ################################################
// Opcodes, widths and flag layout of the execute
// pipeline. Files refer to these by scoped name.
// ################################################

`default_nettype none

package exec_pkg;

  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 4;

  // Shared immediate field for relative branches and inc/dec
  localparam int OFFSET_W  = 10;
  localparam int INCDEC_W  = 8;

  // Relative branch targets count from the following halfword
  localparam int PC_INC    = 2;

  typedef enum logic [6:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_ASHL, OP_ASHR, OP_LSHR,
    OP_INC, OP_DEC,
    OP_MOV, OP_NEG, OP_NOT,
    OP_SEX_B, OP_SEX_S, OP_ZEX_B, OP_ZEX_S,
    OP_LDI,
    OP_CMP,
    OP_BEQ, OP_BNE, OP_BLT, OP_BLTU, OP_BGT,
    OP_BGTU, OP_BLE, OP_BLEU, OP_BGE, OP_BGEU,
    OP_JMPA,
    // Register indirect stores
    OP_ST_B, OP_ST_S, OP_ST_L,
    // Absolute stores
    OP_STA_B, OP_STA_S, OP_STA_L,
    // Offset stores
    OP_STO_B, OP_STO_S, OP_STO_L,
    OP_NOP
  } opcode_e;

  // Condition flags written by cmp
  typedef struct packed {
    logic eq;
    logic lt;
    logic gt;
    logic ltu;
    logic gtu;
  } cc_t;

endpackage

`default_nettype wire

/* design/exec_store.sv */
// ################################################
// Store sequencer. Turns one store into one or two
// 16-bit writes on the data-memory bus, high half
// first for long stores.
// ################################################

`default_nettype none

module exec_store
(
  input  logic                              clk_i,
  input  logic                              rst_i,
  exec_if.sink                              iss,
  output logic                              busy_o,
  output logic [dmem_pkg::DADDR_W-1:0]      dmem_addr_o,
  output logic [dmem_pkg::DDATA_W-1:0]      dmem_data_o,
  output logic [dmem_pkg::SEL_W-1:0]        dmem_sel_o,
  output logic                              dmem_stb_o,
  output logic                              dmem_cyc_o,
  output logic                              dmem_we_o,
  input  logic                              dmem_ack_i
);

  localparam int DW = dmem_pkg::DDATA_W;

  dmem_pkg::store_state_e         state;
  logic                           is_store;
  logic                           is_long;
  logic                           start;
  logic [dmem_pkg::DADDR_W-1:0]   st_addr;
  logic [exec_pkg::XLEN-1:0]      st_data;
  logic [DW-1:0]                  st_first;
  logic [dmem_pkg::SEL_W-1:0]     st_sel;
  logic [DW-1:0]                  low_half;

  // Decode addressing mode and size
  always_comb
  begin
    is_store = 1'b1;
    is_long  = 1'b0;
    st_addr  = iss.reg_a;
    st_data  = iss.reg_b;
    st_sel   = dmem_pkg::SEL_HALF;
    st_first = st_data[DW-1:0];
    case (iss.op)
      exec_pkg::OP_ST_B, exec_pkg::OP_ST_S, exec_pkg::OP_ST_L:
        st_addr = iss.reg_a;
      exec_pkg::OP_STA_B, exec_pkg::OP_STA_S, exec_pkg::OP_STA_L:
      begin
        st_addr = iss.operand;
        st_data = iss.reg_a;
      end
      exec_pkg::OP_STO_B, exec_pkg::OP_STO_S, exec_pkg::OP_STO_L:
        st_addr = iss.operand + iss.reg_a;
      default:
        is_store = 1'b0;
    endcase
    case (iss.op)
      exec_pkg::OP_ST_B, exec_pkg::OP_STA_B, exec_pkg::OP_STO_B:
      begin
        st_sel   = dmem_pkg::SEL_BYTE;
        st_first = {{(DW-8){1'b0}}, st_data[7:0]};
      end
      exec_pkg::OP_ST_L, exec_pkg::OP_STA_L, exec_pkg::OP_STO_L:
      begin
        is_long  = 1'b1;
        st_first = st_data[exec_pkg::XLEN-1 -: DW];
      end
      default:
        st_first = st_data[DW-1:0];
    endcase
  end

  assign start = iss.valid & is_store & (state == dmem_pkg::ST_IDLE);

  // Also busy while a store waits in the issue register
  assign busy_o = (state != dmem_pkg::ST_IDLE) | (iss.valid & is_store);

  // Short and byte stores go straight to the final half
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state      <= dmem_pkg::ST_IDLE;
      dmem_stb_o <= 1'b0;
      dmem_cyc_o <= 1'b0;
      dmem_we_o  <= 1'b0;
    end
    else
    begin
      case (state)
        dmem_pkg::ST_IDLE:
          if (start)
          begin
            dmem_stb_o <= 1'b1;
            dmem_cyc_o <= 1'b1;
            dmem_we_o  <= 1'b1;
            state      <= is_long ? dmem_pkg::ST_FIRST : dmem_pkg::ST_SECOND;
          end
        dmem_pkg::ST_FIRST:
          if (dmem_ack_i)
          begin
            state <= dmem_pkg::ST_SECOND;
          end
        dmem_pkg::ST_SECOND:
          if (dmem_ack_i)
          begin
            dmem_stb_o <= 1'b0;
            dmem_cyc_o <= 1'b0;
            dmem_we_o  <= 1'b0;
            state      <= dmem_pkg::ST_IDLE;
          end
        default:
          state <= dmem_pkg::ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (start)
    begin
      dmem_addr_o <= st_addr;
      dmem_data_o <= st_first;
      dmem_sel_o  <= st_sel;
      low_half    <= st_data[DW-1:0];
    end
    else if (state == dmem_pkg::ST_FIRST && dmem_ack_i)
    begin
      // Low half goes to the next halfword
      dmem_addr_o <= dmem_addr_o + dmem_pkg::DADDR_W'(dmem_pkg::HALF_STEP);
      dmem_data_o <= low_half;
    end
  end

endmodule

`default_nettype wire

/* design/exec_top.sv */
// ################################################
// Execute pipeline top level. Issue register, ALU
// stage and store sequencer on one instruction bus.
// ################################################

`default_nettype none

module exec_top
(
  input  logic                             clk_i,
  input  logic                             rst_i,

  // Instruction in
  input  logic                             valid_i,
  input  exec_pkg::opcode_e                op_i,
  input  logic [exec_pkg::XLEN-1:0]        reg_a_i,
  input  logic [exec_pkg::XLEN-1:0]        reg_b_i,
  input  logic [exec_pkg::XLEN-1:0]        operand_i,
  input  logic [exec_pkg::OFFSET_W-1:0]    offset_i,
  input  logic [exec_pkg::XLEN-1:0]        pc_i,
  input  logic [exec_pkg::REG_IDX_W-1:0]   dst_idx_i,
  output logic                             ready_o,

  // Register write-back
  output logic                             reg_we_o,
  output logic [exec_pkg::XLEN-1:0]        result_o,
  output logic [exec_pkg::REG_IDX_W-1:0]   dst_idx_o,

  // Branch redirect
  output logic                             branch_o,
  output logic [exec_pkg::XLEN-1:0]        branch_target_o,

  // Data memory
  output logic [dmem_pkg::DADDR_W-1:0]     dmem_addr_o,
  output logic [dmem_pkg::DDATA_W-1:0]     dmem_data_o,
  output logic [dmem_pkg::SEL_W-1:0]       dmem_sel_o,
  output logic                             dmem_stb_o,
  output logic                             dmem_cyc_o,
  output logic                             dmem_we_o,
  input  logic                             dmem_ack_i
);

  logic store_busy;

  exec_if iss_bus ();

  exec_issue u_issue
  (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .valid_i   (valid_i),
    .op_i      (op_i),
    .reg_a_i   (reg_a_i),
    .reg_b_i   (reg_b_i),
    .operand_i (operand_i),
    .offset_i  (offset_i),
    .pc_i      (pc_i),
    .dst_idx_i (dst_idx_i),
    .busy_i    (store_busy),
    .ready_o   (ready_o),
    .iss       (iss_bus.issue)
  );

  exec_alu u_alu
  (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .iss             (iss_bus.sink),
    .reg_we_o        (reg_we_o),
    .result_o        (result_o),
    .dst_idx_o       (dst_idx_o),
    .branch_o        (branch_o),
    .branch_target_o (branch_target_o)
  );

  exec_store u_store
  (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .iss         (iss_bus.sink),
    .busy_o      (store_busy),
    .dmem_addr_o (dmem_addr_o),
    .dmem_data_o (dmem_data_o),
    .dmem_sel_o  (dmem_sel_o),
    .dmem_stb_o  (dmem_stb_o),
    .dmem_cyc_o  (dmem_cyc_o),
    .dmem_we_o   (dmem_we_o),
    .dmem_ack_i  (dmem_ack_i)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the execute pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module exec_tb -f verilog.f

./obj_dir/Vexec_tb > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
  exit 1
fi
exit 0

/* tests/exec_assertions.sv */
// ################################################
// Data-memory protocol checks, bound into the
// store sequencer by the testbench.
// ################################################

`default_nettype none

module exec_store_assertions
(
  input logic clk_i,
  input logic rst_i,
  input logic start_i,
  input logic busy_i,
  input logic stb_i,
  input logic cyc_i,
  input logic ack_i
);

  logic store_seen;

  // Set once the first store starts after reset
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      store_seen <= 1'b0;
    end
    else if (start_i)
    begin
      store_seen <= 1'b1;
    end
  end

  stb_needs_cyc: assert property (@(posedge clk_i) disable iff (rst_i) stb_i |-> cyc_i)
    else $error("strobe without cycle");

  stb_until_ack: assert property (@(posedge clk_i) disable iff (rst_i)
                                  stb_i && !ack_i |=> stb_i)
    else $error("strobe dropped before ack");

  busy_with_stb: assert property (@(posedge clk_i) disable iff (rst_i) stb_i |-> busy_i)
    else $error("strobe while not busy");

  no_early_stb: assert property (@(posedge clk_i) disable iff (rst_i)
                                 !store_seen |-> !stb_i)
    else $error("strobe before any store");

endmodule

`default_nettype wire

/* tests/exec_tb.sv */
// ################################################
// Table-driven testbench for the execute pipeline.
// Drives instructions, answers the memory bus with
// random ack delays and checks all side effects.
// ################################################

`default_nettype none

module exec_tb;

  localparam int PERIOD = 20;

  typedef struct packed {
    exec_pkg::opcode_e op;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       operand;
    logic [9:0]        offset;
    logic [31:0]       pc;
    logic [3:0]        dst;
    // Expected write-back, only when wr is set
    logic              wr;
    logic [31:0]       res;
  } row_t;

  logic              clk_i;
  logic              rst_i;
  logic              valid_i;
  exec_pkg::opcode_e op_i;
  logic [31:0]       reg_a_i;
  logic [31:0]       reg_b_i;
  logic [31:0]       operand_i;
  logic [9:0]        offset_i;
  logic [31:0]       pc_i;
  logic [3:0]        dst_idx_i;
  logic              ready_o;
  logic              reg_we_o;
  logic [31:0]       result_o;
  logic [3:0]        dst_idx_o;
  logic              branch_o;
  logic [31:0]       branch_target_o;
  logic [31:0]       dmem_addr_o;
  logic [15:0]       dmem_data_o;
  logic [1:0]        dmem_sel_o;
  logic              dmem_stb_o;
  logic              dmem_cyc_o;
  logic              dmem_we_o;
  logic              dmem_ack_i;

  row_t        tbl[$];
  logic        tbl_built;
  logic [35:0] wb_q[$];
  logic [31:0] br_q[$];
  logic [49:0] st_q[$];
  int unsigned wait_cnt;
  int          errors;
  int          fails;

  exec_top u_dut
  (
    .clk_i (clk_i), .rst_i (rst_i), .valid_i (valid_i), .op_i (op_i),
    .reg_a_i (reg_a_i), .reg_b_i (reg_b_i), .operand_i (operand_i),
    .offset_i (offset_i), .pc_i (pc_i), .dst_idx_i (dst_idx_i), .ready_o (ready_o),
    .reg_we_o (reg_we_o), .result_o (result_o), .dst_idx_o (dst_idx_o),
    .branch_o (branch_o), .branch_target_o (branch_target_o),
    .dmem_addr_o (dmem_addr_o), .dmem_data_o (dmem_data_o), .dmem_sel_o (dmem_sel_o),
    .dmem_stb_o (dmem_stb_o), .dmem_cyc_o (dmem_cyc_o), .dmem_we_o (dmem_we_o),
    .dmem_ack_i (dmem_ack_i)
  );

  bind exec_store exec_store_assertions u_sva
  (
    .clk_i (clk_i), .rst_i (rst_i), .start_i (start), .busy_i (busy_o),
    .stb_i (dmem_stb_o), .cyc_i (dmem_cyc_o), .ack_i (dmem_ack_i)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(PERIOD/2) clk_i = ~clk_i;
  end

  // Memory responder with 0 to 3 wait cycles per write
  always @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      dmem_ack_i <= 1'b0;
      wait_cnt   <= 0;
    end
    else if (dmem_ack_i)
    begin
      dmem_ack_i <= 1'b0;
      wait_cnt   <= $urandom % 4;
    end
    else if (dmem_stb_o && dmem_cyc_o && dmem_we_o)
    begin
      if (wait_cnt == 0)
      begin
        dmem_ack_i <= 1'b1;
        st_q.push_back({dmem_addr_o, dmem_data_o, dmem_sel_o});
      end
      else
      begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

  always @(posedge clk_i)
  begin
    if (reg_we_o)
      wb_q.push_back({dst_idx_o, result_o});
    if (branch_o)
      br_q.push_back(branch_target_o);
  end

  task automatic add_row(input exec_pkg::opcode_e op, input logic [31:0] a,
                         input logic [31:0] b, input logic [31:0] operand,
                         input logic [9:0] offset, input logic wr,
                         input logic [31:0] res);
    row_t r;
    r.op      = op;
    r.a       = a;
    r.b       = b;
    r.operand = operand;
    r.offset  = offset;
    r.pc      = 32'h1000 + 32'(tbl.size() * 4);
    r.dst     = 4'(tbl.size());
    r.wr      = wr;
    r.res     = res;
    tbl.push_back(r);
  endtask

  // Branch outcome from the operands of the last cmp
  function automatic logic cond_ref(exec_pkg::opcode_e op, logic [31:0] x, logic [31:0] y);
    case (op)
      exec_pkg::OP_BEQ:  return x == y;
      exec_pkg::OP_BNE:  return x != y;
      exec_pkg::OP_BLT:  return $signed(x) < $signed(y);
      exec_pkg::OP_BLTU: return x < y;
      exec_pkg::OP_BGT:  return $signed(x) > $signed(y);
      exec_pkg::OP_BGTU: return x > y;
      exec_pkg::OP_BLE:  return $signed(x) <= $signed(y);
      exec_pkg::OP_BLEU: return x <= y;
      exec_pkg::OP_BGE:  return $signed(x) >= $signed(y);
      exec_pkg::OP_BGEU: return x >= y;
      default:           return 1'b0;
    endcase
  endfunction

  // Expected writes of a store, high half first for long stores
  task automatic store_ref(input row_t r, output int n, output logic [49:0] w0,
                           output logic [49:0] w1);
    logic [31:0] addr;
    logic [31:0] data;
    addr = r.a;
    data = r.b;
    case (r.op)
      exec_pkg::OP_STA_B, exec_pkg::OP_STA_S, exec_pkg::OP_STA_L:
      begin
        addr = r.operand;
        data = r.a;
      end
      exec_pkg::OP_STO_B, exec_pkg::OP_STO_S, exec_pkg::OP_STO_L:
        addr = r.operand + r.a;
      default:
        addr = r.a;
    endcase
    w0 = {addr, data[15:0], 2'b11};
    w1 = {addr + 32'd2, data[15:0], 2'b11};
    case (r.op)
      exec_pkg::OP_ST_B, exec_pkg::OP_STA_B, exec_pkg::OP_STO_B:
      begin
        n  = 1;
        w0 = {addr, 8'h0, data[7:0], 2'b01};
      end
      exec_pkg::OP_ST_S, exec_pkg::OP_STA_S, exec_pkg::OP_STO_S:
        n = 1;
      exec_pkg::OP_ST_L, exec_pkg::OP_STA_L, exec_pkg::OP_STO_L:
      begin
        n  = 2;
        w0 = {addr, data[31:16], 2'b11};
      end
      default:
        n = 0;
    endcase
  endtask

  task automatic build_table();
    exec_pkg::opcode_e br_ops[10];
    exec_pkg::opcode_e st_ops[9];
    logic [31:0]       pair_a[3];
    logic [31:0]       pair_b[3];
    br_ops = '{exec_pkg::OP_BEQ, exec_pkg::OP_BNE, exec_pkg::OP_BLT, exec_pkg::OP_BLTU,
               exec_pkg::OP_BGT, exec_pkg::OP_BGTU, exec_pkg::OP_BLE, exec_pkg::OP_BLEU,
               exec_pkg::OP_BGE, exec_pkg::OP_BGEU};
    st_ops = '{exec_pkg::OP_ST_B, exec_pkg::OP_ST_S, exec_pkg::OP_ST_L,
               exec_pkg::OP_STA_B, exec_pkg::OP_STA_S, exec_pkg::OP_STA_L,
               exec_pkg::OP_STO_B, exec_pkg::OP_STO_S, exec_pkg::OP_STO_L};
    pair_a = '{32'hFFFF_FFFB, 32'h0000_0007, 32'h0000_0002};
    pair_b = '{32'h0000_0003, 32'h0000_0007, 32'h8000_0000};
    add_row(exec_pkg::OP_ADD,   32'h7FFF_FFFF, 32'h0000_0002, 0, 0, 1'b1, 32'h8000_0001);
    add_row(exec_pkg::OP_SUB,   32'h0000_0003, 32'h0000_0005, 0, 0, 1'b1, 32'hFFFF_FFFE);
    add_row(exec_pkg::OP_AND,   32'hF0F0_1234, 32'h0FF0_FF00, 0, 0, 1'b1, 32'h00F0_1200);
    add_row(exec_pkg::OP_OR,    32'hF000_0001, 32'h000F_0010, 0, 0, 1'b1, 32'hF00F_0011);
    add_row(exec_pkg::OP_XOR,   32'hAAAA_5555, 32'hFFFF_0000, 0, 0, 1'b1, 32'h5555_5555);
    add_row(exec_pkg::OP_ASHL,  32'h8000_0013, 32'd4, 0, 0, 1'b1, 32'h0000_0130);
    add_row(exec_pkg::OP_ASHR,  32'h8000_0F00, 32'd3, 0, 0, 1'b1, 32'hF000_01E0);
    add_row(exec_pkg::OP_LSHR,  32'h8000_0F00, 32'd5, 0, 0, 1'b1, 32'h0400_0078);
    add_row(exec_pkg::OP_INC,   32'h0000_0100, 0, 0, 10'h3FF, 1'b1, 32'h0000_01FF);
    add_row(exec_pkg::OP_DEC,   32'h0000_0100, 0, 0, 10'h105, 1'b1, 32'h0000_00FB);
    add_row(exec_pkg::OP_MOV,   0, 32'hDEAD_BEEF, 0, 0, 1'b1, 32'hDEAD_BEEF);
    add_row(exec_pkg::OP_NEG,   0, 32'h0000_0001, 0, 0, 1'b1, 32'hFFFF_FFFF);
    add_row(exec_pkg::OP_NOT,   0, 32'h0F0F_0000, 0, 0, 1'b1, 32'hF0F0_FFFF);
    add_row(exec_pkg::OP_SEX_B, 0, 32'h1234_5680, 0, 0, 1'b1, 32'hFFFF_FF80);
    add_row(exec_pkg::OP_SEX_S, 0, 32'h1234_8001, 0, 0, 1'b1, 32'hFFFF_8001);
    add_row(exec_pkg::OP_ZEX_B, 0, 32'hFFFF_FF80, 0, 0, 1'b1, 32'h0000_0080);
    add_row(exec_pkg::OP_ZEX_S, 0, 32'hFFFF_8001, 0, 0, 1'b1, 32'h0000_8001);
    add_row(exec_pkg::OP_LDI,   0, 0, 32'hCAFE_F00D, 0, 1'b1, 32'hCAFE_F00D);
    for (int p = 0; p < 3; p++)
    begin
      add_row(exec_pkg::OP_CMP, pair_a[p], pair_b[p], 0, 0, 1'b0, 0);
      for (int k = 0; k < 10; k++)
      begin
        // Alternate forward and backward offsets
        add_row(br_ops[k], 0, 0, 0, (k % 2) ? 10'(k * 5) : 10'h3F0 - 10'(k), 1'b0, 0);
        add_row(exec_pkg::OP_ADD, 32'(k), 32'(p * 100), 0, 0, 1'b1, 32'(k + p * 100));
      end
    end
    add_row(exec_pkg::OP_JMPA, 0, 0, 32'h0000_8000, 0, 1'b0, 0);
    add_row(exec_pkg::OP_STA_L, 32'h1111_2222, 0, 32'h0000_0300, 0, 1'b0, 0);
    for (int k = 0; k < 9; k++)
    begin
      add_row(st_ops[k], 32'h8765_2000 + 32'(k * 16), 32'hA1B2_C3D4 ^ 32'(k),
              32'h0000_4000, 0, 1'b0, 0);
    end
    add_row(exec_pkg::OP_LDI, 0, 0, 32'h0000_0042, 0, 1'b1, 32'h0000_0042);
    tbl_built = 1'b1;
  endtask

  task automatic check_results();
    logic [31:0] ca;
    logic [31:0] cb;
    logic        prev_taken;
    logic        taken;
    logic        ok;
    logic [49:0] w[2];
    logic [35:0] got_wb;
    logic [49:0] got_st;
    logic [31:0] tgt;
    int          n;
    ca         = 0;
    cb         = 0;
    prev_taken = 1'b0;
    foreach (tbl[i])
    begin
      ok    = 1'b1;
      taken = 1'b0;
      if (!prev_taken)
      begin
        if (tbl[i].op == exec_pkg::OP_CMP)
        begin
          ca = tbl[i].a;
          cb = tbl[i].b;
        end
        if (tbl[i].wr)
        begin
          assert (wb_q.size() > 0)
          else
          begin
            $display("Row %0d is missing its register write-back", i);
            ok = 1'b0;
          end
          if (wb_q.size() > 0)
          begin
            got_wb = wb_q.pop_front();
            assert (got_wb == {tbl[i].dst, tbl[i].res})
            else
            begin
              $display("FAIL t=%0t row %0d: write-back %h expected %h", $time, i,
                       got_wb, {tbl[i].dst, tbl[i].res});
              ok = 1'b0;
            end
          end
        end
        taken = (tbl[i].op == exec_pkg::OP_JMPA) || cond_ref(tbl[i].op, ca, cb);
        if (taken)
        begin
          tgt = (tbl[i].op == exec_pkg::OP_JMPA) ? tbl[i].operand :
                tbl[i].pc + 32'd2 + ({{22{tbl[i].offset[9]}}, tbl[i].offset} << 1);
          assert (br_q.size() > 0 && br_q[0] == tgt)
          else
          begin
            $display("FAIL t=%0t row %0d: branch to %h missing or wrong", $time, i, tgt);
            ok = 1'b0;
          end
          if (br_q.size() > 0)
            void'(br_q.pop_front());
        end
        store_ref(tbl[i], n, w[0], w[1]);
        for (int s = 0; s < n; s++)
        begin
          got_st = (st_q.size() > 0) ? st_q.pop_front() : 50'h0;
          assert (got_st == w[s])
          else
          begin
            $display("FAIL t=%0t row %0d: store %h expected %h", $time, i, got_st, w[s]);
            ok = 1'b0;
          end
        end
      end
      prev_taken = taken;
      $display("test %0d %s: %s", i, tbl[i].op.name(), ok ? "pass" : "fail");
      if (!ok)
        fails++;
    end
    assert (wb_q.size() == 0 && br_q.size() == 0 && st_q.size() == 0)
    else
    begin
      $display("The DUT produced write-backs, branches or stores that were not expected");
      errors++;
    end
  endtask

  initial
  begin
    void'($urandom(32'h4686));
    tbl_built = 1'b0;
    errors    = 0;
    fails     = 0;
    rst_i     = 1'b1;
    valid_i   = 1'b0;
    op_i      = exec_pkg::OP_NOP;
    reg_a_i   = '0;
    reg_b_i   = '0;
    operand_i = '0;
    offset_i  = '0;
    pc_i      = '0;
    dst_idx_i = '0;
    build_table();
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    foreach (tbl[i])
    begin
      valid_i   <= 1'b1;
      op_i      <= tbl[i].op;
      reg_a_i   <= tbl[i].a;
      reg_b_i   <= tbl[i].b;
      operand_i <= tbl[i].operand;
      offset_i  <= tbl[i].offset;
      pc_i      <= tbl[i].pc;
      dst_idx_i <= tbl[i].dst;
      @(posedge clk_i);
      while (!ready_o)
        @(posedge clk_i);
    end
    valid_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    while (!ready_o || dmem_cyc_o)
      @(posedge clk_i);
    repeat (3) @(posedge clk_i);
    check_results();
    $display("Tests run %0d, failed %0d, other errors %0d", tbl.size(), fails, errors);
    if (fails == 0 && errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  // Watchdog sized from the table length
  initial
  begin
    #1;
    wait (tbl_built);
    #(tbl.size() * 20 * PERIOD);
    $display("Timeout: the run did not finish within the expected time");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
design/exec_pkg.sv
design/dmem_pkg.sv
design/exec_if.sv
design/exec_issue.sv
design/exec_alu.sv
design/exec_store.sv
design/exec_top.sv
tests/exec_assertions.sv
tests/exec_tb.sv
